// File: sparcIsaPkg.sv
// SPARC integer ISA constants used by the control unit
`default_nettype none

package sparcIsaPkg;

        localparam int DataW = 32;

        // register windows
        localparam int NumWindows = 8;
        localparam int CwpW = 3;

        // instruction field positions
        localparam int OpLsb = 30;          // op in ir[31:30]
        localparam int Op2Lsb = 22;         // op2 in ir[24:22]
        localparam int Op3Lsb = 19;         // op3 in ir[24:19]
        localparam int CondLsb = 25;        // cond in ir[28:25]
        localparam int StoreBit = 21;       // set for stores
        localparam int ImmBit = 13;         // simm13 instead of rs2

        localparam logic [1:0] OpBranch = 2'b00;
        localparam logic [1:0] OpCall = 2'b01;
        localparam logic [1:0] OpArith = 2'b10;
        localparam logic [1:0] OpMem = 2'b11;

        localparam logic [2:0] Op2Sethi = 3'b100;
        localparam logic [2:0] Op2Bicc = 3'b010;

        localparam logic [5:0] Op3Save = 6'b111100;
        localparam logic [5:0] Op3Restore = 6'b111101;
        localparam logic [5:0] Op3Ticc = 6'b111010;

        // icc bit order
        localparam int IccN = 3;
        localparam int IccZ = 2;
        localparam int IccV = 1;
        localparam int IccC = 0;

        typedef logic [3:0] condT;

        localparam int unsigned AddrLimit = 508;   // highest legal word address

        typedef logic [7:0] ttT;

        localparam ttT TrapWinOverflow = 8'h05;
        localparam ttT TrapWinUnderflow = 8'h06;
        localparam ttT TrapBadAddr = 8'h07;
        localparam ttT TrapTicc = 8'h80;

endpackage

`default_nettype wire

// File: ctrlPkg.sv
// Control unit types for sequencer states, datapath selects and trap requests
`default_nettype none

package ctrlPkg;

        typedef enum logic [4:0] {
                sFetch,
                sIfWait,
                sIrLoad,
                sDecode,
                sSethi,
                sAlu,
                sBranch,
                sWinWrite,
                sMemAddr,
                sLoadWait,
                sLoadMdr,
                sLoadWrite,
                sStoreMdr,
                sStoreWait,
                sEnd,
                sTrap
        } seqStateT;

        typedef enum logic [1:0] {
                aluResult,
                mdrData,
                pcValue
        } rfSrcT;

        typedef enum logic {
                regB,
                imm
        } aluBSrcT;

        typedef enum logic [1:0] {
                opPass,
                opAdd,
                opAlu         // datapath decodes op3
        } aluOpT;

        typedef enum logic [1:0] {
                npcSeq,
                npcDisp,
                npcTrap
        } npcSrcT;

        typedef enum logic {
                marPc,
                marAlu
        } marSrcT;

        // one bit per trap cause, highest priority first
        typedef struct packed {
                logic badAddr;
                logic winOver;
                logic winUnder;
                logic ticc;
        } trapReqT;

endpackage

`default_nettype wire

// File: ctrlIfs.sv
// Internal interfaces between the sequencer, the window checker and the trap queue
`timescale 1ns/100ps
`default_nettype none

interface winIf import sparcIsaPkg::*; ();

        logic save;
        logic restore;
        logic enterTrap;
        logic [CwpW-1:0] cwp;
        logic overflow;         // combinational from cwp and wim
        logic underflow;

        modport seq (output save, restore, enterTrap, input cwp, overflow, underflow);
        modport check (input save, restore, enterTrap, output cwp, overflow, underflow);

endinterface

interface trapIf import sparcIsaPkg::*, ctrlPkg::*; ();

        trapReqT req;           // one-cycle request pulses
        logic take;
        logic pending;
        ttT tt;

        modport seq (output req, take, input pending, tt);
        modport queue (input req, take, output pending, tt);

endinterface

`default_nettype wire

// File: condEval.sv
// Branch and trap condition evaluator over the integer condition codes
`timescale 1ns/100ps
`default_nettype none

module condEval import sparcIsaPkg::*;
(
        input  condT        cond,
        input  logic [3:0]  icc,
        output logic        taken
);

        logic base;

        always_comb
        begin
                case (cond[2:0])
                3'd0: base = 1'b0;
                3'd1: base = icc[IccZ];
                3'd2: base = icc[IccZ] | (icc[IccN] ^ icc[IccV]);
                3'd3: base = icc[IccN] ^ icc[IccV];
                3'd4: base = icc[IccC] | icc[IccZ];
                3'd5: base = icc[IccC];
                3'd6: base = icc[IccN];
                default: base = icc[IccV];
                endcase
                taken = base ^ cond[3];         // upper eight invert the lower eight
        end

endmodule

`default_nettype wire

// File: windowCheck.sv
// Current window pointer with overflow and underflow detection against the WIM
`timescale 1ns/100ps
`default_nettype none

module windowCheck import sparcIsaPkg::*;
(
        input  logic                  Clk,
        input  logic                  rstN,
        input  logic [NumWindows-1:0] wim,
        winIf.check                   win
);

        logic [CwpW-1:0] cwpReg;
        logic [CwpW-1:0] cwpDec;
        logic [CwpW-1:0] cwpInc;

        // wraps modulo the window count
        assign cwpDec = cwpReg - 1'b1;
        assign cwpInc = cwpReg + 1'b1;

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                        cwpReg <= '0;
                else if (win.enterTrap)
                        cwpReg <= '0;
                else if (win.save)
                        cwpReg <= cwpDec;
                else if (win.restore)
                        cwpReg <= cwpInc;
        end

        assign win.cwp = cwpReg;
        assign win.overflow = wim[cwpDec];      // save would enter an invalid window
        assign win.underflow = wim[cwpInc];

endmodule

`default_nettype wire

// File: trapQueue.sv
// Pending trap collector with fixed-priority trap type selection
`timescale 1ns/100ps
`default_nettype none

module trapQueue import sparcIsaPkg::*, ctrlPkg::*;
(
        input  logic  Clk,
        input  logic  rstN,
        trapIf.queue  trap
);

        trapReqT pendReg;

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                        pendReg <= '0;
                else if (trap.take)
                        pendReg <= '0;
                else
                        pendReg <= pendReg | trap.req;
        end

        assign trap.pending = |pendReg;

        always_comb
        begin
                if (pendReg.badAddr)
                        trap.tt = TrapBadAddr;
                else if (pendReg.winOver)
                        trap.tt = TrapWinOverflow;
                else if (pendReg.winUnder)
                        trap.tt = TrapWinUnderflow;
                else if (pendReg.ticc)
                        trap.tt = TrapTicc;
                else
                        trap.tt = '0;
        end

endmodule

`default_nettype wire

// File: ctrlSequencer.sv
// Fetch, decode and execute state machine driving the datapath strobes
`timescale 1ns/100ps
`default_nettype none

module ctrlSequencer import sparcIsaPkg::*, ctrlPkg::*;
(
        input  logic              Clk,
        input  logic              rstN,
        input  logic [DataW-1:0]  ir,
        input  logic [DataW-1:0]  aluAddr,
        input  logic              mfc,
        input  logic              taken,
        output condT              cond,
        output logic              mfa,
        output logic              memWrite,
        output logic              irLoad,
        output logic              marLoad,
        output marSrcT            marSrc,
        output logic              mdrLoad,
        output logic              rfWrite,
        output rfSrcT             rfSrc,
        output aluBSrcT           aluBSrc,
        output aluOpT             aluOp,
        output logic              pcLoad,
        output logic              npcLoad,
        output npcSrcT            npcSrc,
        output logic              trapEntry,
        winIf.seq                 win,
        trapIf.seq                trap
);

        seqStateT state;
        seqStateT stateNext;
        logic [1:0] op;
        logic [2:0] op2;
        logic [5:0] op3;

        assign op = ir[OpLsb +: 2];
        assign op2 = ir[Op2Lsb +: 3];
        assign op3 = ir[Op3Lsb +: 6];
        assign cond = ir[CondLsb +: 4];

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                        state <= sFetch;
                else
                        state <= stateNext;
        end

        // memory request held through the wait states
        assign mfa = (state == sIfWait) || (state == sLoadWait) || (state == sStoreWait);
        assign memWrite = (state == sStoreWait);

        always_comb
        begin
                stateNext = state;
                irLoad = 1'b0;
                marLoad = 1'b0;
                marSrc = marPc;
                mdrLoad = 1'b0;
                rfWrite = 1'b0;
                rfSrc = aluResult;
                aluBSrc = ir[ImmBit] ? imm : regB;
                aluOp = opAdd;
                pcLoad = 1'b0;
                npcLoad = 1'b0;
                npcSrc = npcSeq;
                trapEntry = 1'b0;
                win.save = 1'b0;
                win.restore = 1'b0;
                win.enterTrap = 1'b0;
                trap.req = '0;
                trap.take = 1'b0;

                case (state)
                sFetch:
                begin
                        marLoad = 1'b1;
                        stateNext = sIfWait;
                end
                sIfWait:
                        if (mfc)
                                stateNext = sIrLoad;
                sIrLoad:
                begin
                        irLoad = 1'b1;
                        stateNext = sDecode;
                end
                sDecode:
                begin
                        stateNext = sEnd;
                        case (op)
                        OpBranch:
                                if (op2 == Op2Sethi)
                                        stateNext = sSethi;
                                else if (op2 == Op2Bicc)
                                        stateNext = taken ? sBranch : sEnd;
                                else
                                        trap.req.badAddr = 1'b1;   // illegal op2
                        OpCall:
                                trap.req.badAddr = 1'b1;
                        OpArith:
                                if (op3 == Op3Save)
                                begin
                                        trap.req.winOver = win.overflow;
                                        win.save = !win.overflow;
                                        stateNext = win.overflow ? sEnd : sWinWrite;
                                end
                                else if (op3 == Op3Restore)
                                begin
                                        trap.req.winUnder = win.underflow;
                                        win.restore = !win.underflow;
                                        stateNext = win.underflow ? sEnd : sWinWrite;
                                end
                                else if (op3 == Op3Ticc)
                                        trap.req.ticc = taken;
                                else
                                        stateNext = sAlu;
                        OpMem:
                                stateNext = sMemAddr;
                        endcase
                end
                sSethi:
                begin
                        aluOp = opPass;
                        aluBSrc = imm;
                        rfWrite = 1'b1;
                        stateNext = sEnd;
                end
                sAlu:
                begin
                        aluOp = opAlu;
                        rfWrite = 1'b1;
                        stateNext = sEnd;
                end
                sBranch:
                begin
                        npcLoad = 1'b1;
                        npcSrc = npcDisp;
                        stateNext = sEnd;
                end
                sWinWrite:
                begin
                        rfWrite = 1'b1;         // rd in the new window
                        stateNext = sEnd;
                end
                sMemAddr:
                begin
                        marLoad = 1'b1;
                        marSrc = marAlu;
                        if (aluAddr > AddrLimit)
                        begin
                                trap.req.badAddr = 1'b1;
                                stateNext = sEnd;
                        end
                        else
                                stateNext = ir[StoreBit] ? sStoreMdr : sLoadWait;
                end
                sLoadWait:
                        if (mfc)
                                stateNext = sLoadMdr;
                sLoadMdr:
                begin
                        mdrLoad = 1'b1;
                        stateNext = sLoadWrite;
                end
                sLoadWrite:
                begin
                        rfWrite = 1'b1;
                        rfSrc = mdrData;
                        stateNext = sEnd;
                end
                sStoreMdr:
                begin
                        mdrLoad = 1'b1;
                        stateNext = sStoreWait;
                end
                sStoreWait:
                        if (mfc)
                                stateNext = sEnd;
                sEnd:
                begin
                        pcLoad = 1'b1;
                        npcLoad = 1'b1;
                        stateNext = trap.pending ? sTrap : sFetch;
                end
                sTrap:
                begin
                        trapEntry = 1'b1;
                        npcLoad = 1'b1;
                        npcSrc = npcTrap;
                        rfWrite = 1'b1;
                        rfSrc = pcValue;        // save pc into the trap window
                        win.enterTrap = 1'b1;
                        trap.take = 1'b1;
                        stateNext = sFetch;
                end
                default:
                        stateNext = sFetch;
                endcase
        end

endmodule

`default_nettype wire

// File: sparcCtrl.sv
// SPARC multi-cycle control unit top level
`timescale 1ns/100ps
`default_nettype none

module sparcCtrl import sparcIsaPkg::*, ctrlPkg::*;
(
        input  logic                  Clk,
        input  logic                  rstN,
        input  logic [DataW-1:0]      ir,
        input  logic [3:0]            icc,
        input  logic [NumWindows-1:0] wim,
        input  logic [DataW-1:0]      aluAddr,
        input  logic                  mfc,
        output logic                  mfa,
        output logic                  memWrite,
        output logic                  irLoad,
        output logic                  marLoad,
        output marSrcT                marSrc,
        output logic                  mdrLoad,
        output logic                  rfWrite,
        output rfSrcT                 rfSrc,
        output aluBSrcT               aluBSrc,
        output aluOpT                 aluOp,
        output logic                  pcLoad,
        output logic                  npcLoad,
        output npcSrcT                npcSrc,
        output logic                  trapEntry,
        output logic [CwpW-1:0]       cwp,
        output ttT                    tt
);

        condT cond;
        logic taken;

        winIf win ();
        trapIf trap ();

        assign cwp = win.cwp;
        assign tt = trap.tt;

        ctrlSequencer ctrlSequencer_i (
                .Clk       (Clk),
                .rstN      (rstN),
                .ir        (ir),
                .aluAddr   (aluAddr),
                .mfc       (mfc),
                .taken     (taken),
                .cond      (cond),
                .mfa       (mfa),
                .memWrite  (memWrite),
                .irLoad    (irLoad),
                .marLoad   (marLoad),
                .marSrc    (marSrc),
                .mdrLoad   (mdrLoad),
                .rfWrite   (rfWrite),
                .rfSrc     (rfSrc),
                .aluBSrc   (aluBSrc),
                .aluOp     (aluOp),
                .pcLoad    (pcLoad),
                .npcLoad   (npcLoad),
                .npcSrc    (npcSrc),
                .trapEntry (trapEntry),
                .win       (win.seq),
                .trap      (trap.seq)
        );

        condEval condEval_i (
                .cond  (cond),
                .icc   (icc),
                .taken (taken)
        );

        windowCheck windowCheck_i (
                .Clk  (Clk),
                .rstN (rstN),
                .wim  (wim),
                .win  (win.check)
        );

        trapQueue trapQueue_i (
                .Clk  (Clk),
                .rstN (rstN),
                .trap (trap.queue)
        );

endmodule

`default_nettype wire

// File: clkGen.sv
// Testbench clock and reset generator
`timescale 1ns/100ps
`default_nettype none

module clkGen
#(
        parameter int Period = 8,
        parameter int ResetCycles = 10
)
(
        output logic Clk,
        output logic rstN
);

        initial
        begin
                Clk = 1'b0;
                forever #(Period / 2) Clk = ~Clk;
        end

        initial
        begin
                rstN = 1'b0;
                repeat (ResetCycles) @(posedge Clk);
                @(negedge Clk);
                rstN = 1'b1;            // released mid-cycle
        end

endmodule

`default_nettype wire

// File: sparcCtrl_asserts.sv
// Concurrent checks on the memory handshake and the control strobes
`timescale 1ns/100ps
`default_nettype none

module sparcCtrl_asserts import ctrlPkg::*;
(
        input  logic    Clk,
        input  logic    rstN,
        input  logic    mfa,
        input  logic    mfc,
        input  logic    irLoad,
        input  logic    marLoad,
        input  marSrcT  marSrc,
        input  logic    trapEntry,
        input  logic    pcLoad,
        input  logic    npcLoad,
        input  npcSrcT  npcSrc
);

        mfaHold: assert property (@(posedge Clk) disable iff (!rstN) mfa && !mfc |=> mfa)
                else $error("mfa dropped before mfc was seen");

        // ir loads only once the fetch has completed
        irNotMfa: assert property (@(posedge Clk) disable iff (!rstN)
                irLoad |-> !mfa && $past(mfa && mfc))
                else $error("irLoad raised while mfa is high or before mfc");

        // trap entry hands over to a fresh fetch
        trapFetch: assert property (@(posedge Clk) disable iff (!rstN)
                trapEntry |=> marLoad && marSrc == marPc)
                else $error("trap entry not followed by a fetch marLoad");

        pcWithNpc: assert property (@(posedge Clk) disable iff (!rstN)
                pcLoad |-> npcLoad && npcSrc == npcSeq && !$past(pcLoad))
                else $error("pcLoad without a sequential npcLoad or longer than one cycle");

endmodule

bind sparcCtrl sparcCtrl_asserts sparcCtrl_asserts_i (.*);

`default_nettype wire

// File: sparcCtrlTb.sv
// Table-driven testbench for the SPARC control unit, acting as memory
`timescale 1ns/100ps
`default_nettype none

module sparcCtrlTb import sparcIsaPkg::*, ctrlPkg::*;
();

        localparam int MaxDelay = 5;
        localparam int ResetCycles = 10;

        typedef struct packed {
                logic [31:0] ir;
                logic [3:0]  icc;
                logic [7:0]  wim;
                logic [31:0] aluAddr;
                int          mfcDelay;  // negative picks a random delay
                logic        expTaken;
                logic        expTrap;
                ttT          expTt;
                logic [2:0]  expCwp;
                logic        hasWr;
                rfSrcT       wrSrc;
                aluOpT       expAluOp;
                aluBSrcT     expBSrc;
                logic        hasMem;
        } testT;

        logic Clk, rstN, mfc, mfa, memWrite, irLoad, marLoad, mdrLoad, rfWrite;
        logic pcLoad, npcLoad, trapEntry;
        logic [DataW-1:0] ir, aluAddr;
        logic [3:0] icc;
        logic [NumWindows-1:0] wim;
        logic [CwpW-1:0] cwp;
        marSrcT marSrc;
        rfSrcT rfSrc, wrSrc;
        aluBSrcT aluBSrc, wrBSrc;
        aluOpT aluOp, wrAluOp;
        npcSrcT npcSrc;
        ttT tt, trapTt;

        testT tests[$];
        string names[$];
        string curName;
        integer seed = 28;
        int cycleCount = 0;
        int cycleLimit = 0;
        int passCnt = 0;
        int failCnt = 0;
        int testErr, curDelay, accDelay, waitCnt, dispCnt, wrCnt, mdrCnt, dataMfa, marCnt;
        logic seenIr, endSeen, trapSeen, dataDone, earlyWr, memWr;

        clkGen #(.Period(8), .ResetCycles(ResetCycles)) clkGen_i (.Clk(Clk), .rstN(rstN));

        sparcCtrl sparcCtrl_i (.*);

        function automatic logic condHolds(input logic [3:0] c, input logic [3:0] f);
                logic n, z, v, cy, r;
                n = f[IccN];
                z = f[IccZ];
                v = f[IccV];
                cy = f[IccC];
                case (c)
                4'd8: r = 1'b1;
                4'd0: r = 1'b0;
                4'd9: r = !z;
                4'd1: r = z;
                4'd10: r = !(z | (n ^ v));
                4'd2: r = z | (n ^ v);
                4'd11: r = !(n ^ v);
                4'd3: r = n ^ v;
                4'd12: r = !(cy | z);
                4'd4: r = cy | z;
                4'd13: r = !cy;
                4'd5: r = cy;
                4'd14: r = !n;
                4'd6: r = n;
                4'd15: r = !v;
                default: r = v;
                endcase
                return r;
        endfunction

        function automatic logic [31:0] arithInstr(input logic [5:0] op3, input logic i);
                return {OpArith, 5'd1, op3, 5'd2, i, 13'h0005};
        endfunction

        function automatic logic [31:0] memInstr(input logic store);
                return {OpMem, 5'd4, 3'b000, store, 2'b00, 5'd2, 1'b1, 13'h0008};
        endfunction

        task automatic addTest(input string n, input logic [31:0] i, input logic [3:0] c,
                input logic [7:0] w, input logic [31:0] a, input int d, input logic tk,
                input logic tp, input ttT ttV, input logic [2:0] cw, input logic hw,
                input rfSrcT ws, input aluOpT op, input aluBSrcT bs, input logic hm);
                names.push_back(n);
                tests.push_back({i, c, w, a, d, tk, tp, ttV, cw, hw, ws, op, bs, hm});
        endtask

        task automatic buildTests();
                logic [3:0] rIcc;
                logic hit;
                // window ops first, cwp walks 0 -> 7 -> 0 -> 1 then traps back to 0
                addTest("save", arithInstr(Op3Save, 1'b0), 4'h0, 8'h00, 32'd0, 1,
                        1'b0, 1'b0, 8'h00, 3'd7, 1'b1, aluResult, opAdd, regB, 1'b0);
                addTest("restore", arithInstr(Op3Restore, 1'b0), 4'h0, 8'h00, 32'd0, 0,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b1, aluResult, opAdd, regB, 1'b0);
                addTest("restoreOtherWim", arithInstr(Op3Restore, 1'b0), 4'h0, 8'h01, 32'd0, 2,
                        1'b0, 1'b0, 8'h00, 3'd1, 1'b1, aluResult, opAdd, regB, 1'b0);
                addTest("saveOverflow", arithInstr(Op3Save, 1'b0), 4'h0, 8'h01, 32'd0, 0,
                        1'b0, 1'b1, TrapWinOverflow, 3'd0, 1'b0, aluResult, opAdd, regB, 1'b0);
                addTest("restoreUnderflow", arithInstr(Op3Restore, 1'b0), 4'h0, 8'h02, 32'd0, 1,
                        1'b0, 1'b1, TrapWinUnderflow, 3'd0, 1'b0, aluResult, opAdd, regB, 1'b0);
                addTest("aluReg", arithInstr(6'b000000, 1'b0), 4'h0, 8'h00, 32'd0, 0,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b1, aluResult, opAlu, regB, 1'b0);
                addTest("aluImm", arithInstr(6'b000010, 1'b1), 4'h0, 8'h00, 32'd0, 3,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b1, aluResult, opAlu, imm, 1'b0);
                addTest("sethi", {OpBranch, 5'd3, Op2Sethi, 22'h0}, 4'h0, 8'h00, 32'd0, 0,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b1, aluResult, opPass, imm, 1'b0);
                addTest("loadAtLimit", memInstr(1'b0), 4'h0, 8'h00, 32'd508, 3,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b1, mdrData, opAdd, regB, 1'b1);
                addTest("store", memInstr(1'b1), 4'h0, 8'h00, 32'd100, 2,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b0, aluResult, opAdd, regB, 1'b1);
                addTest("loadRandom", memInstr(1'b0), 4'h0, 8'h00, 32'd40, -1,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b1, mdrData, opAdd, regB, 1'b1);
                addTest("storeRandom", memInstr(1'b1), 4'h0, 8'h00, 32'd12, -1,
                        1'b0, 1'b0, 8'h00, 3'd0, 1'b0, aluResult, opAdd, regB, 1'b1);
                addTest("loadBadAddr", memInstr(1'b0), 4'h0, 8'h00, 32'd509, 1,
                        1'b0, 1'b1, TrapBadAddr, 3'd0, 1'b0, aluResult, opAdd, regB, 1'b0);
                addTest("call", {OpCall, 30'h100}, 4'h0, 8'h00, 32'd0, 0,
                        1'b0, 1'b1, TrapBadAddr, 3'd0, 1'b0, aluResult, opAdd, regB, 1'b0);
                addTest("badOp2", {OpBranch, 5'd0, 3'b000, 22'h0}, 4'h0, 8'h00, 32'd0, 2,
                        1'b0, 1'b1, TrapBadAddr, 3'd0, 1'b0, aluResult, opAdd, regB, 1'b0);
                for (int c = 0; c < 32; c++)
                begin
                        rIcc = 4'($random(seed));
                        hit = condHolds(4'(c), rIcc);
                        addTest($sformatf("bicc%0d_%h", c % 16, rIcc),
                                {OpBranch, 1'b0, 4'(c), Op2Bicc, 22'h000010}, rIcc, 8'h00,
                                32'd0, -1, hit, 1'b0, 8'h00, 3'd0, 1'b0, aluResult, opAdd,
                                regB, 1'b0);
                end
                for (int c = 0; c < 16; c++)
                begin
                        rIcc = 4'($random(seed));
                        hit = condHolds(4'(c), rIcc);
                        addTest($sformatf("ticc%0d_%h", c, rIcc),
                                {OpArith, 1'b0, 4'(c), Op3Ticc, 5'd0, 1'b1, 13'h0003}, rIcc,
                                8'h00, 32'd0, -1, 1'b0, hit, hit ? TrapTicc : 8'h00, 3'd0,
                                1'b0, aluResult, opAdd, regB, 1'b0);
                end
        endtask

        task automatic checkVal(input string what, input int expV, input int actV);
                assert (expV == actV)
                else
                begin
                        $display("ERR %s %s expected %0h actual %0h", curName, what, expV, actV);
                        testErr++;
                end
        endtask

        // one clock of sampling plus the memory model
        task automatic stepCycle();
                @(negedge Clk);
                if (irLoad)
                        seenIr = 1'b1;
                if (trapEntry)
                begin
                        trapSeen = 1'b1;
                        trapTt = tt;
                end
                else if (rfWrite)
                begin
                        wrCnt++;
                        wrSrc = rfSrc;
                        wrAluOp = aluOp;
                        wrBSrc = aluBSrc;
                        if (rfSrc == mdrData && !dataDone)
                                earlyWr = 1'b1;
                end
                if (npcLoad && npcSrc == npcDisp)
                        dispCnt++;
                if (pcLoad && npcLoad && npcSrc == npcSeq)
                        endSeen = 1'b1;
                if (mdrLoad)
                        mdrCnt++;
                if (marLoad && marSrc == marAlu)
                        marCnt++;
                if (seenIr && mfa)
                begin
                        dataMfa++;
                        memWr = memWr | memWrite;
                end
                if (seenIr && !mfa && dataMfa > 0)
                        dataDone = 1'b1;
                if (mfa)
                begin
                        if (waitCnt == 0)
                                accDelay = (curDelay < 0) ?
                                        int'($unsigned($random(seed)) % (MaxDelay + 1)) : curDelay;
                        mfc = (waitCnt == accDelay);
                        waitCnt++;
                end
                else
                begin
                        mfc = 1'b0;
                        waitCnt = 0;
                end
        endtask

        task automatic runTest(input int idx);
                testT t;
                t = tests[idx];
                curName = names[idx];
                ir = t.ir;
                icc = t.icc;
                wim = t.wim;
                aluAddr = t.aluAddr;
                curDelay = t.mfcDelay;
                {seenIr, endSeen, trapSeen, dataDone, earlyWr, memWr} = '0;
                {testErr, dispCnt, wrCnt, mdrCnt, dataMfa, marCnt} = '0;
                while (!endSeen)
                        stepCycle();
                stepCycle();                    // trap entry or the next fetch
                if (trapSeen)
                        stepCycle();            // cwp settles after trap entry
                checkVal("branch taken", int'(t.expTaken), dispCnt);
                checkVal("trap", int'(t.expTrap), int'(trapSeen));
                if (t.expTrap)
                        checkVal("tt", int'(t.expTt), int'(trapTt));
                checkVal("cwp", int'(t.expCwp), int'(cwp));
                checkVal("rf writes", int'(t.hasWr), wrCnt);
                if (t.hasWr && wrCnt == 1)
                        checkVal("rfSrc", int'(t.wrSrc), int'(wrSrc));
                if (t.hasWr && t.wrSrc == aluResult && wrCnt == 1)
                begin
                        checkVal("aluOp", int'(t.expAluOp), int'(wrAluOp));
                        checkVal("aluBSrc", int'(t.expBSrc), int'(wrBSrc));
                end
                checkVal("marAlu loads", int'(t.ir[OpLsb +: 2] == OpMem), marCnt);
                checkVal("data mfa cycles", t.hasMem ? accDelay + 1 : 0, dataMfa);
                checkVal("mdrLoad", int'(t.hasMem), mdrCnt);
                if (t.hasMem)
                        checkVal("memWrite", int'(t.ir[StoreBit]), int'(memWr));
                assert (!earlyWr)
                else
                begin
                        $display("%s: register file took memory data before mfc", curName);
                        testErr++;
                end
                if (testErr == 0)
                        passCnt++;
                else
                        failCnt++;
                $display("%-20s %s", curName, (testErr == 0) ? "pass" : "fail");
        endtask

        always @(posedge Clk)
        begin
                cycleCount = cycleCount + 1;
                if (cycleLimit > 0 && cycleCount > cycleLimit)
                begin
                        $display("Timeout: tests did not complete within %0d cycles", cycleLimit);
                        $display("Errors found");
                        $finish;
                end
        end

        initial
        begin
                ir = '0;
                icc = '0;
                wim = '0;
                aluAddr = '0;
                mfc = 1'b0;
                waitCnt = 0;
                accDelay = 0;
                buildTests();
                cycleLimit = tests.size() * (40 + MaxDelay) + ResetCycles;
                @(posedge rstN);
                for (int i = 0; i < tests.size(); i++)
                        runTest(i);
                $display("tests %0d, passed %0d, failed %0d", tests.size(), passCnt, failCnt);
                if (failCnt == 0)
                        $display("No errors");
                else
                        $display("Errors found");
                $finish;
        end

endmodule

`default_nettype wire

// File: build.f
sparcIsaPkg.sv
ctrlPkg.sv
ctrlIfs.sv
condEval.sv
windowCheck.sv
trapQueue.sv
ctrlSequencer.sv
sparcCtrl.sv
clkGen.sv
sparcCtrl_asserts.sv
sparcCtrlTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sparcCtrlTb
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	-$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
